// ==== verilog.f ====
mhq_pkg.sv
mhq_lookup.sv
mhq_entry_array.sv
mhq_fill.sv
mhq_top.sv
tb_mhq.sv

// ==== Makefile ====
.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_mhq: verilog.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mhq -f verilog.f

# Pass or fail is taken from the simulation output
run: obj_dir/Vtb_mhq
	@out="$$(./obj_dir/Vtb_mhq)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// ==== tb_mhq.sv ====
// ####################
// MHQ testbench
// Table driven lookups and memory responses checked against a
// byte level reference model of the queue, with a watchdog
// ####################

`timescale 1ns/1ns

module tb_mhq;
    import mhq_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_ROWS   = 24;

    // Base byte addresses of the five cache lines used by the table
    localparam logic [ADDR_W-1:0] LINE_A = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] LINE_B = 32'h0000_2040;
    localparam logic [ADDR_W-1:0] LINE_C = 32'h0000_3080;
    localparam logic [ADDR_W-1:0] LINE_D = 32'h0000_40c0;
    localparam logic [ADDR_W-1:0] LINE_E = 32'h0000_5100;

    // One table row with the lookup, the memory response flag and the expected flags
    typedef struct packed {
        logic                 lk;
        logic                 dc_hit;
        mhq_op_e              op;
        logic [ADDR_W-1:0]    addr;
        logic [DATA_W-1:0]    data;
        logic                 rsp;
        logic [MHQ_IDX_W-1:0] tag;
        logic                 retry;
        logic                 replay;
    } row_t;

    logic                   clk;
    logic                   i_rst;
    logic                   i_lookup_valid;
    mhq_req_t               i_lookup;
    logic                   i_mem_rsp_valid;
    logic [LINE_W-1:0]      i_mem_rsp_data;
    logic [MHQ_IDX_W-1:0]   o_lookup_tag;
    logic                   o_lookup_retry;
    logic                   o_lookup_replay;
    logic                   o_mem_req_valid;
    logic [LINE_ADDR_W-1:0] o_mem_req_addr;
    logic                   o_fill_valid;
    mhq_fill_t              o_fill;

    row_t rows[$];
    row_t prev_row;

    // Reference copy of the queue with one slot per entry in allocation order
    logic [LINE_ADDR_W-1:0] m_addr [MHQ_DEPTH];
    logic [7:0]             m_byte [MHQ_DEPTH][LINE_BYTES];
    logic                   m_set  [MHQ_DEPTH][LINE_BYTES];
    int                     m_head;
    int                     m_tail;
    int                     m_count;

    // A memory read is outstanding in the current cycle
    logic                   out_q;
    logic                   req_now;
    logic                   exp_fill_valid;
    mhq_fill_t              exp_fill;
    logic [LINE_W-1:0]      mem_data;
    integer                 seed;
    int                     row_errors;
    int                     total_errors;
    int                     failed_tests;

    mhq_top mhq_top_i (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_lookup_valid  (i_lookup_valid),
        .i_lookup        (i_lookup),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp_data  (i_mem_rsp_data),
        .o_lookup_tag    (o_lookup_tag),
        .o_lookup_retry  (o_lookup_retry),
        .o_lookup_replay (o_lookup_replay),
        .o_mem_req_valid (o_mem_req_valid),
        .o_mem_req_addr  (o_mem_req_addr),
        .o_fill_valid    (o_fill_valid),
        .o_fill          (o_fill)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Every row gets a generous budget of cycles
    initial begin
        repeat (NUM_ROWS * 20) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the table finished", NUM_ROWS * 20);
        $display("Regression failed");
        $finish;
    end

    task automatic add_row(input logic lk, input logic dc_hit, input mhq_op_e op,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic rsp, input logic [MHQ_IDX_W-1:0] tag,
                           input logic retry, input logic replay);
        rows.push_back({lk, dc_hit, op, addr, data, rsp, tag, retry, replay});
    endtask

    task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
            row_errors++;
        end
    endtask

    // A miss goes into the queue unless it hit, retried or replayed
    function automatic logic accepted(input row_t r);
        return r.lk && !r.dc_hit && (r.op != OP_FILL) && !r.retry && !r.replay;
    endfunction

    // Merge into the pending entry of the line or open a new one at the tail
    task automatic model_store(input row_t r);
        int                     slot;
        int                     nbytes;
        int                     off;
        logic [LINE_ADDR_W-1:0] line;
        line = r.addr[ADDR_W-1:OFFSET_W];
        off  = int'(r.addr[OFFSET_W-1:0]);
        slot = -1;
        for (int i = 0; i < m_count; i++) begin
            if (m_addr[(m_head + i) % MHQ_DEPTH] == line) begin
                slot = (m_head + i) % MHQ_DEPTH;
            end
        end
        if (slot < 0) begin
            slot = m_tail;
            m_addr[slot] = line;
            for (int b = 0; b < LINE_BYTES; b++) begin
                m_set[slot][b] = 1'b0;
            end
            m_tail = (m_tail + 1) % MHQ_DEPTH;
            m_count++;
        end
        case (r.op)
            OP_SB:   nbytes = 1;
            OP_SH:   nbytes = 2;
            OP_SW:   nbytes = 4;
            default: nbytes = 0;
        endcase
        // Bytes past the end of the line are dropped
        for (int j = 0; j < nbytes; j++) begin
            if (off + j < LINE_BYTES) begin
                m_byte[slot][off + j] = r.data[j*8 +: 8];
                m_set[slot][off + j]  = 1'b1;
            end
        end
    endtask

    // Memory returns the oldest line and stored bytes win over memory bytes
    task automatic complete_head();
        assert (out_q) else begin
            $display("Memory response driven while no read is outstanding");
            row_errors++;
        end
        mem_data = {$random(seed), $random(seed), $random(seed), $random(seed)};
        i_mem_rsp_data = mem_data;
        exp_fill.addr = m_addr[m_head];
        for (int b = 0; b < LINE_BYTES; b++) begin
            exp_fill.data[b*8 +: 8] = m_set[m_head][b] ? m_byte[m_head][b] : mem_data[b*8 +: 8];
        end
        if (m_count > 0) begin
            m_head = (m_head + 1) % MHQ_DEPTH;
            m_count--;
        end
    endtask

    // Called on a falling edge when the results of the previous row have settled
    task automatic sample_outputs();
        req_now = (m_count > 0) && !out_q;
        check_value("o_lookup_retry", o_lookup_retry, prev_row.retry);
        check_value("o_lookup_replay", o_lookup_replay, prev_row.replay);
        if (accepted(prev_row)) begin
            check_value("o_lookup_tag", o_lookup_tag, prev_row.tag);
        end
        check_value("o_fill_valid", o_fill_valid, exp_fill_valid);
        if (exp_fill_valid) begin
            check_value("o_fill.addr", o_fill.addr, exp_fill.addr);
            check_value("o_fill.data", o_fill.data, exp_fill.data);
        end
        check_value("o_mem_req_valid", o_mem_req_valid, req_now);
        if (req_now) begin
            check_value("o_mem_req_addr", o_mem_req_addr, m_addr[m_head]);
        end
    endtask

    task automatic finish_test(input string name);
        if (row_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, row_errors);
            failed_tests++;
        end
        total_errors += row_errors;
        row_errors = 0;
    endtask

    task automatic drive_row(input row_t r);
        i_lookup_valid  = r.lk;
        i_lookup.we     = r.op inside {OP_SB, OP_SH, OP_SW};
        i_lookup.dc_hit = r.dc_hit;
        i_lookup.addr   = r.addr;
        i_lookup.op     = r.op;
        i_lookup.data   = r.data;
        i_mem_rsp_valid = r.rsp;
        i_mem_rsp_data  = '0;
    endtask

    task automatic build_table();
        // Idle after reset
        add_row(1'b0, 1'b0, OP_LOAD, 32'h0, 32'h0, 1'b0, 2'd0, 1'b0, 1'b0);
        add_row(1'b0, 1'b0, OP_LOAD, 32'h0, 32'h0, 1'b0, 2'd0, 1'b0, 1'b0);
        // Three stores gather in entry 0 through the bypass and then by match
        add_row(1'b1, 1'b0, OP_SW, LINE_A + 32'h4, 32'h1122_3344, 1'b0, 2'd0, 1'b0, 1'b0);
        add_row(1'b1, 1'b0, OP_SB, LINE_A + 32'h9, 32'h0000_00ab, 1'b0, 2'd0, 1'b0, 1'b0);
        add_row(1'b1, 1'b0, OP_SH, LINE_A + 32'he, 32'h0000_cdef, 1'b0, 2'd0, 1'b0, 1'b0);
        // New lines take the next tail entries and a load miss allocates as well
        add_row(1'b1, 1'b0, OP_SW, LINE_B + 32'h0, 32'h5566_7788, 1'b0, 2'd1, 1'b0, 1'b0);
        add_row(1'b1, 1'b0, OP_LOAD, LINE_C + 32'h8, 32'h0, 1'b0, 2'd2, 1'b0, 1'b0);
        add_row(1'b1, 1'b1, OP_SW, LINE_D + 32'h0, 32'hdead_beef, 1'b0, 2'd0, 1'b0, 1'b0);
        add_row(1'b1, 1'b0, OP_SB, LINE_D + 32'h3, 32'h0000_005a, 1'b0, 2'd3, 1'b0, 1'b0);
        // With four lines pending a fifth line retries and a pending line still merges
        add_row(1'b1, 1'b0, OP_SW, LINE_E + 32'h0, 32'h99aa_bbcc, 1'b0, 2'd0, 1'b1, 1'b0);
        add_row(1'b1, 1'b0, OP_SB, LINE_B + 32'h5, 32'h0000_00c3, 1'b0, 2'd1, 1'b0, 1'b0);
        add_row(1'b0, 1'b0, OP_LOAD, 32'h0, 32'h0, 1'b1, 2'd0, 1'b0, 1'b0);
        // A store to line A in its fill cycle replays
        add_row(1'b1, 1'b0, OP_SB, LINE_A + 32'h0, 32'h0000_00ee, 1'b0, 2'd0, 1'b0, 1'b1);
        add_row(1'b1, 1'b0, OP_SW, LINE_E + 32'h0, 32'h99aa_bbcc, 1'b0, 2'd0, 1'b0, 1'b0);
        add_row(1'b1, 1'b0, OP_SH, LINE_D + 32'h6, 32'h0000_1234, 1'b0, 2'd3, 1'b0, 1'b0);
        // Line B returns while a store to it replays
        add_row(1'b1, 1'b0, OP_SB, LINE_B + 32'h8, 32'h0000_0077, 1'b1, 2'd0, 1'b0, 1'b1);
        add_row(1'b1, 1'b0, OP_LOAD, LINE_D + 32'h0, 32'h0, 1'b0, 2'd3, 1'b0, 1'b0);
        add_row(1'b0, 1'b0, OP_LOAD, 32'h0, 32'h0, 1'b1, 2'd0, 1'b0, 1'b0);
        add_row(1'b0, 1'b0, OP_LOAD, 32'h0, 32'h0, 1'b0, 2'd0, 1'b0, 1'b0);
        add_row(1'b0, 1'b0, OP_LOAD, 32'h0, 32'h0, 1'b1, 2'd0, 1'b0, 1'b0);
        add_row(1'b0, 1'b0, OP_LOAD, 32'h0, 32'h0, 1'b0, 2'd0, 1'b0, 1'b0);
        // This store reaches the head in the cycle its response arrives
        add_row(1'b1, 1'b0, OP_SB, LINE_E + 32'hf, 32'h0000_0042, 1'b0, 2'd0, 1'b0, 1'b0);
        add_row(1'b0, 1'b0, OP_LOAD, 32'h0, 32'h0, 1'b1, 2'd0, 1'b0, 1'b0);
        add_row(1'b0, 1'b0, OP_LOAD, 32'h0, 32'h0, 1'b0, 2'd0, 1'b0, 1'b0);
    endtask

    initial begin
        seed            = 32'ha10c_a898;
        i_rst           = 1'b1;
        i_lookup_valid  = 1'b0;
        i_lookup        = '0;
        i_mem_rsp_valid = 1'b0;
        i_mem_rsp_data  = '0;
        prev_row        = '0;
        exp_fill_valid  = 1'b0;
        exp_fill        = '0;
        out_q           = 1'b0;
        req_now         = 1'b0;
        m_head          = 0;
        m_tail          = 0;
        m_count         = 0;
        row_errors      = 0;
        total_errors    = 0;
        failed_tests    = 0;
        build_table();
        assert (rows.size() == NUM_ROWS) else begin
            $display("Stimulus table holds %0d rows instead of %0d", rows.size(), NUM_ROWS);
            total_errors++;
        end
        // Reset spans five rising edges and drops on the falling edge after them
        repeat (5) @(posedge clk);
        @(negedge clk);
        i_rst = 1'b0;
        // Out of reset nothing is pending, retried, requested or filled
        sample_outputs();
        finish_test("reset");
        for (int k = 0; k < rows.size(); k++) begin
            drive_row(rows[k]);
            if (rows[k].rsp) begin
                complete_head();
            end
            // The outstanding read starts or ends at the next rising edge
            if (req_now) begin
                out_q = 1'b1;
            end else if (rows[k].rsp) begin
                out_q = 1'b0;
            end
            exp_fill_valid = rows[k].rsp;
            if (accepted(rows[k])) begin
                model_store(rows[k]);
            end
            @(negedge clk);
            prev_row = rows[k];
            sample_outputs();
            finish_test($sformatf("row %0d", k));
        end
        $display("%0d tests, %0d failed, %0d errors", rows.size() + 1, failed_tests,
                 total_errors);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== mhq_top.sv ====
// ####################
// MHQ top level
// Lookup, entry array and fill stages of the data cache miss queue
// ####################

`timescale 1ns/1ns

module mhq_top (
    input  logic                            clk,
    input  logic                            i_rst,
    input  logic                            i_lookup_valid,
    input  mhq_pkg::mhq_req_t               i_lookup,
    input  logic                            i_mem_rsp_valid,
    input  logic [mhq_pkg::LINE_W-1:0]      i_mem_rsp_data,
    output logic [mhq_pkg::MHQ_IDX_W-1:0]   o_lookup_tag,
    output logic                            o_lookup_retry,
    output logic                            o_lookup_replay,
    output logic                            o_mem_req_valid,
    output logic [mhq_pkg::LINE_ADDR_W-1:0] o_mem_req_addr,
    output logic                            o_fill_valid,
    output mhq_pkg::mhq_fill_t              o_fill
);
    import mhq_pkg::*;

    // Array state back to lookup
    logic [MHQ_DEPTH-1:0]   hit_select;
    logic [MHQ_DEPTH-1:0]   alloc_select;
    logic                   full;

    // Registered update, also fed back to lookup as the bypass
    mhq_update_t            update;

    // Head entry and its release
    mhq_entry_t             head;
    logic                   release_head;

    // Fill conflict information for replay
    logic                   completing;
    logic [LINE_ADDR_W-1:0] completing_addr;
    logic                   filling;

    mhq_lookup mhq_lookup_i (
        .clk               (clk),
        .i_rst             (i_rst),
        .i_lookup_valid    (i_lookup_valid),
        .i_lookup          (i_lookup),
        .i_hit_select      (hit_select),
        .i_alloc_select    (alloc_select),
        .i_full            (full),
        .i_bypass          (update),
        .i_completing      (completing),
        .i_completing_addr (completing_addr),
        .i_filling         (filling),
        .i_filling_addr    (o_fill.addr),
        .o_lookup_tag      (o_lookup_tag),
        .o_lookup_retry    (o_lookup_retry),
        .o_lookup_replay   (o_lookup_replay),
        .o_update          (update)
    );

    mhq_entry_array mhq_entry_array_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_lookup_addr  (i_lookup.addr[ADDR_W-1:OFFSET_W]),
        .i_update       (update),
        .i_release      (release_head),
        .o_hit_select   (hit_select),
        .o_alloc_select (alloc_select),
        .o_full         (full),
        .o_head         (head)
    );

    mhq_fill mhq_fill_i (
        .clk               (clk),
        .i_rst             (i_rst),
        .i_head            (head),
        .i_mem_rsp_valid   (i_mem_rsp_valid),
        .i_mem_rsp_data    (i_mem_rsp_data),
        .o_mem_req_valid   (o_mem_req_valid),
        .o_mem_req_addr    (o_mem_req_addr),
        .o_release         (release_head),
        .o_completing      (completing),
        .o_completing_addr (completing_addr),
        .o_filling         (filling),
        .o_fill_valid      (o_fill_valid),
        .o_fill            (o_fill)
    );

endmodule

// ==== mhq_fill.sv ====
// ####################
// MHQ fill stage
// Sends the head line to memory, overlays its store bytes on the
// returned line, frees the entry and emits the fill
// ####################

`timescale 1ns/1ns

module mhq_fill (
    input  logic                            clk,
    input  logic                            i_rst,
    input  mhq_pkg::mhq_entry_t             i_head,
    input  logic                            i_mem_rsp_valid,
    input  logic [mhq_pkg::LINE_W-1:0]      i_mem_rsp_data,
    output logic                            o_mem_req_valid,
    output logic [mhq_pkg::LINE_ADDR_W-1:0] o_mem_req_addr,
    output logic                            o_release,
    output logic                            o_completing,
    output logic [mhq_pkg::LINE_ADDR_W-1:0] o_completing_addr,
    output logic                            o_filling,
    output logic                            o_fill_valid,
    output mhq_pkg::mhq_fill_t              o_fill
);
    import mhq_pkg::*;

    logic              outstanding_q;
    logic              fill_valid_q;
    mhq_fill_t         fill_q;
    logic [LINE_W-1:0] merged_line;

    // Only one read to memory at a time, always for the head entry
    assign o_mem_req_valid = i_head.valid & ~outstanding_q;
    assign o_mem_req_addr  = i_head.addr;

    // The response belongs to the head, which is freed in the same cycle
    assign o_completing      = i_mem_rsp_valid & outstanding_q;
    assign o_completing_addr = i_head.addr;
    assign o_release         = o_completing;

    // Stored bytes take precedence over what memory returned
    assign merged_line = merge_bytes(i_mem_rsp_data, i_head.data, i_head.byte_mask);

    always_ff @(posedge clk) begin
        if (o_completing) begin
            fill_q.addr <= i_head.addr;
            fill_q.data <= merged_line;
        end
        if (i_rst) begin
            outstanding_q <= 1'b0;
            fill_valid_q  <= 1'b0;
        end else begin
            if (o_mem_req_valid) begin
                outstanding_q <= 1'b1;
            end else if (o_completing) begin
                outstanding_q <= 1'b0;
            end
            // Fill goes out exactly one cycle after the response
            fill_valid_q <= o_completing;
        end
    end

    // The filling strobe tells lookup which line is landing in the cache
    assign o_filling    = fill_valid_q;
    assign o_fill_valid = fill_valid_q;
    assign o_fill       = fill_q;

endmodule

// ==== mhq_entry_array.sv ====
// ####################
// MHQ entry array
// Four in-order entries with line address match, store byte merge,
// head and tail pointers and the full flag
// ####################

`timescale 1ns/1ns

module mhq_entry_array (
    input  logic                            clk,
    input  logic                            i_rst,
    input  logic [mhq_pkg::LINE_ADDR_W-1:0] i_lookup_addr,
    input  mhq_pkg::mhq_update_t            i_update,
    input  logic                            i_release,
    output logic [mhq_pkg::MHQ_DEPTH-1:0]   o_hit_select,
    output logic [mhq_pkg::MHQ_DEPTH-1:0]   o_alloc_select,
    output logic                            o_full,
    output mhq_pkg::mhq_entry_t             o_head
);
    import mhq_pkg::*;

    mhq_entry_t            entries_q [MHQ_DEPTH];
    mhq_entry_t            entries_upd [MHQ_DEPTH];
    logic [MHQ_IDX_W-1:0]  head_q;
    logic [MHQ_IDX_W-1:0]  tail_q;
    logic [MHQ_IDX_W:0]    count_q;
    logic [MHQ_IDX_W:0]    count_alloc;
    logic [MHQ_IDX_W-1:0]  alloc_idx;
    logic                  alloc_now;
    logic [LINE_BYTES-1:0] wr_mask;

    // An allocation is in flight when a registered update creates an entry
    assign alloc_now = (i_update.select != '0) & i_update.allocating;

    // Loads carry no bytes, only stores touch the data
    assign wr_mask = i_update.we ? i_update.byte_sel : '0;

    // Address match against valid entries in their registered state
    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            o_hit_select[i] = entries_q[i].valid && (entries_q[i].addr == i_lookup_addr);
        end
    end

    // The tail moves at the end of this cycle when an allocation lands, so
    // the next free slot and the fill level look one entry ahead
    assign alloc_idx      = tail_q + MHQ_IDX_W'(alloc_now);
    assign o_alloc_select = MHQ_DEPTH'(1) << alloc_idx;
    assign count_alloc    = count_q + {{MHQ_IDX_W{1'b0}}, alloc_now};
    assign o_full         = (count_alloc >= MHQ_DEPTH);

    // Each entry with this cycle's update applied
    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            entries_upd[i] = entries_q[i];
            if (i_update.select[i]) begin
                if (i_update.allocating) begin
                    // Fresh entry, bytes outside the mask are don't care
                    entries_upd[i].valid     = 1'b1;
                    entries_upd[i].addr      = i_update.addr;
                    entries_upd[i].data      = i_update.wr_data;
                    entries_upd[i].byte_mask = wr_mask;
                end else begin
                    // Later stores overwrite earlier bytes at the same offset
                    entries_upd[i].data      = merge_bytes(entries_q[i].data,
                                                           i_update.wr_data, wr_mask);
                    entries_upd[i].byte_mask = entries_q[i].byte_mask | wr_mask;
                end
            end
        end
    end

    // The fill stage sees the head with any same-cycle store folded in
    assign o_head = entries_upd[head_q];

    always_ff @(posedge clk) begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            entries_q[i].addr      <= entries_upd[i].addr;
            entries_q[i].data      <= entries_upd[i].data;
            entries_q[i].byte_mask <= entries_upd[i].byte_mask;
        end
        if (i_rst) begin
            for (int i = 0; i < MHQ_DEPTH; i++) begin
                entries_q[i].valid <= 1'b0;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            // A released head is dropped at the same edge
            for (int i = 0; i < MHQ_DEPTH; i++) begin
                entries_q[i].valid <= entries_upd[i].valid &
                                      ~(i_release && (head_q == MHQ_IDX_W'(i)));
            end
            if (alloc_now) begin
                tail_q <= tail_q + 1'b1;
            end
            if (i_release) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_alloc - {{MHQ_IDX_W{1'b0}}, i_release};
        end
    end

endmodule

// ==== mhq_lookup.sv ====
// ####################
// MHQ lookup stage
// Picks the queue entry for a miss, flags retry on a full queue and
// replay on a fill conflict, and registers the entry update
// ####################

`timescale 1ns/1ns

module mhq_lookup (
    input  logic                            clk,
    input  logic                            i_rst,
    input  logic                            i_lookup_valid,
    input  mhq_pkg::mhq_req_t               i_lookup,
    input  logic [mhq_pkg::MHQ_DEPTH-1:0]   i_hit_select,
    input  logic [mhq_pkg::MHQ_DEPTH-1:0]   i_alloc_select,
    input  logic                            i_full,
    input  mhq_pkg::mhq_update_t            i_bypass,
    input  logic                            i_completing,
    input  logic [mhq_pkg::LINE_ADDR_W-1:0] i_completing_addr,
    input  logic                            i_filling,
    input  logic [mhq_pkg::LINE_ADDR_W-1:0] i_filling_addr,
    output logic [mhq_pkg::MHQ_IDX_W-1:0]   o_lookup_tag,
    output logic                            o_lookup_retry,
    output logic                            o_lookup_replay,
    output mhq_pkg::mhq_update_t            o_update
);
    import mhq_pkg::*;

    logic [LINE_ADDR_W-1:0] line_addr;
    logic [OFFSET_W-1:0]    offset;
    logic                   entry_hit;
    logic                   bypass_hit;
    logic                   lookup_hit;
    logic [MHQ_DEPTH-1:0]   select_mux;
    logic [MHQ_IDX_W-1:0]   select_idx;
    logic                   retry;
    logic                   replay;
    logic                   update_en;
    logic [LINE_BYTES-1:0]  byte_sel;
    logic [LINE_W-1:0]      wr_data;

    // Split the byte address into line address and offset within the line
    assign line_addr = i_lookup.addr[ADDR_W-1:OFFSET_W];
    assign offset    = i_lookup.addr[OFFSET_W-1:0];

    // The entry written this cycle is not yet in the array match, so its
    // address is compared here as well
    assign entry_hit  = (i_hit_select != '0);
    assign bypass_hit = (i_bypass.select != '0) && (i_bypass.addr == line_addr);
    assign lookup_hit = i_lookup_valid & (entry_hit | bypass_hit);

    // Bypass wins over a match, and the tail is used when nothing matches
    always_comb begin
        if (bypass_hit) begin
            select_mux = i_bypass.select;
        end else if (entry_hit) begin
            select_mux = i_hit_select;
        end else begin
            select_mux = i_alloc_select;
        end
    end

    // One-hot select to entry index for the tag
    always_comb begin
        select_idx = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (select_mux[i]) begin
                select_idx = select_idx | MHQ_IDX_W'(i);
            end
        end
    end

    // A new line cannot be taken while every entry is in use
    assign retry = i_lookup_valid & i_full & ~lookup_hit;

    // The line being completed or filled this cycle must not collect more
    // stores, the request comes back once the fill has gone out
    assign replay = i_lookup_valid &
                    ((i_completing & (i_completing_addr == line_addr)) |
                     (i_filling & (i_filling_addr == line_addr)));

    // Cache hits and fill ops leave the queue alone
    assign update_en = i_lookup_valid & ~i_lookup.dc_hit & (i_lookup.op != OP_FILL) &
                       ~retry & ~replay;

    // Byte mask of the access at the bottom of the line, then moved to
    // its offset, bytes past the end of the line fall off
    always_comb begin
        case (i_lookup.op)
            OP_SB:   byte_sel = LINE_BYTES'(4'b0001);
            OP_SH:   byte_sel = LINE_BYTES'(4'b0011);
            OP_SW:   byte_sel = LINE_BYTES'(4'b1111);
            default: byte_sel = '0;
        endcase
        byte_sel = byte_sel << offset;
    end

    // Store data goes to the same byte position as the mask
    assign wr_data = LINE_W'(i_lookup.data) << {offset, 3'b000};

    always_ff @(posedge clk) begin
        // Payload follows the request every cycle, select says if it counts
        o_lookup_tag     <= select_idx;
        o_update.addr    <= line_addr;
        o_update.wr_data <= wr_data;
        o_update.byte_sel <= byte_sel;
        if (i_rst) begin
            o_lookup_retry      <= 1'b0;
            o_lookup_replay     <= 1'b0;
            o_update.select     <= '0;
            o_update.allocating <= 1'b0;
            o_update.we         <= 1'b0;
        end else begin
            o_lookup_retry      <= retry;
            o_lookup_replay     <= replay;
            o_update.select     <= update_en ? select_mux : '0;
            o_update.allocating <= update_en & ~lookup_hit;
            o_update.we         <= update_en & i_lookup.we;
        end
    end

endmodule

// ==== mhq_pkg.sv ====
// ####################
// MHQ shared definitions
// Queue and line sizes, the request op encoding, the records passed
// between the lookup, entry array and fill stages, and the byte merge
// ####################

package mhq_pkg;

    // Queue geometry, four entries addressed by a two bit index
    localparam int MHQ_DEPTH   = 4;
    localparam int MHQ_IDX_W   = 2;

    // Byte address and store data sizes seen by the load/store unit
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;

    // Cache line geometry
    localparam int LINE_BYTES  = 16;
    localparam int LINE_W      = LINE_BYTES * 8;
    localparam int OFFSET_W    = 4;
    localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

    // Request ops from the load/store unit
    typedef enum logic [2:0] {
        OP_LOAD = 3'd0,
        OP_SB   = 3'd1,
        OP_SH   = 3'd2,
        OP_SW   = 3'd3,
        OP_FILL = 3'd4
    } mhq_op_e;

    // One lookup from the load/store unit
    typedef struct packed {
        logic              we;
        logic              dc_hit;
        logic [ADDR_W-1:0] addr;
        mhq_op_e           op;
        logic [DATA_W-1:0] data;
    } mhq_req_t;

    // Registered update from the lookup stage, select is one-hot or zero
    typedef struct packed {
        logic [MHQ_DEPTH-1:0]   select;
        logic                   allocating;
        logic                   we;
        logic [LINE_ADDR_W-1:0] addr;
        logic [LINE_W-1:0]      wr_data;
        logic [LINE_BYTES-1:0]  byte_sel;
    } mhq_update_t;

    // A queue entry with the store bytes gathered so far
    typedef struct packed {
        logic                   valid;
        logic [LINE_ADDR_W-1:0] addr;
        logic [LINE_W-1:0]      data;
        logic [LINE_BYTES-1:0]  byte_mask;
    } mhq_entry_t;

    // A finished line handed back to the cache
    typedef struct packed {
        logic [LINE_ADDR_W-1:0] addr;
        logic [LINE_W-1:0]      data;
    } mhq_fill_t;

    // Bytes of overlay replace bytes of base wherever the mask bit is set
    function automatic logic [LINE_W-1:0] merge_bytes(
        input logic [LINE_W-1:0]     base,
        input logic [LINE_W-1:0]     overlay,
        input logic [LINE_BYTES-1:0] mask
    );
        logic [LINE_W-1:0] line;
        line = base;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (mask[b]) begin
                line[b*8 +: 8] = overlay[b*8 +: 8];
            end
        end
        return line;
    endfunction

endpackage
